// ==== verilog/sobol_macros.svh ====
`ifndef SOBOL_MACROS_SVH
`define SOBOL_MACROS_SVH

// sample counter n, also sets the table depth
`define INWD 8

// index width out of the lsz detector, log2 of INWD
`define LOGINWD 3

// sample x and direction vector width
`define OUTWD 8

// credits held by the controller after reset
`define CREDITS 4

// wide enough to hold CREDITS
`define CREDITWD 3

`endif

// ==== verilog/sobolPkg.sv ====
package sobolPkg;

    // generator run state
    typedef enum logic {
        IDLE = 1'b0,
        RUN  = 1'b1
    } sobolState_t;

    // command port opcodes
    typedef enum logic [1:0] {
        OP_START   = 2'd0, // enter RUN
        OP_STOP    = 2'd1, // back to IDLE
        OP_RESTART = 2'd2, // clear n and x, state kept
        OP_LOADDIR = 2'd3  // write one direction vector, IDLE only
    } sobolOp_t;

endpackage

// ==== verilog/sobolStepIf.sv ====
`timescale 1ns/1ps
`include "sobol_macros.svh"

interface sobolStepIf;

    logic                step;     // advance n and x this edge
    logic                clear;    // n and x back to 0
    logic                dirWrite;
    logic [`LOGINWD-1:0] dirAddr;
    logic [`OUTWD-1:0]   dirData;
    logic [`LOGINWD-1:0] lszIdx;   // lowest zero of current n
    logic [`OUTWD-1:0]   dirVec;   // V[lszIdx]

    modport ctrl (
        output step, clear, dirWrite, dirAddr, dirData
    );

    modport counter (
        input  step, clear,
        output lszIdx
    );

    // direction table side
    modport vecTable (
        input  dirWrite, dirAddr, dirData, lszIdx,
        output dirVec
    );

    modport acc (
        input step, clear, dirVec
    );

endinterface

// ==== verilog/lszDetect.sv ====
`timescale 1ns/1ps
`include "sobol_macros.svh"

module lszDetect (
    input  logic [`INWD-1:0]    in,     // sample counter n
    output logic [`LOGINWD-1:0] lszIdx  // position of lowest 0 bit
);

    logic [`INWD-1:0] zeroSeen;  // running or of inverted bits
    logic [`INWD-1:0] firstZero; // one hot, lowest zero only

    always_comb begin
        zeroSeen[0]  = ~in[0];
        firstZero[0] = ~in[0];
        for (int i = 1; i < `INWD; i++) begin
            zeroSeen[i]  = zeroSeen[i-1] | ~in[i];
            firstZero[i] = zeroSeen[i] & ~zeroSeen[i-1];
        end
    end

    // one hot to index, all ones input gives 0
    always_comb begin
        lszIdx = '0;
        for (int i = 0; i < `INWD; i++) begin
            if (firstZero[i]) begin
                lszIdx = i[`LOGINWD-1:0];
            end
        end
    end

endmodule

// ==== verilog/sobolIndexCounter.sv ====
`timescale 1ns/1ps
`include "sobol_macros.svh"

module sobolIndexCounter (
    input  logic         clk,
    input  logic         reset,
    sobolStepIf.counter  bus
);

    logic [`INWD-1:0]    n;      // samples taken since clear
    logic [`LOGINWD-1:0] idx;

    always_ff @(posedge clk) begin
        if (reset) begin
            n <= '0;
        end else if (bus.clear) begin
            n <= '0;
        end else if (bus.step) begin
            n <= n + 1'b1; // wraps after all ones
        end
    end

    // index for the current n, ready ahead of the step that uses it
    lszDetect i_lszDetect (
        .in     (n),
        .lszIdx (idx)
    );

    assign bus.lszIdx = idx;

endmodule

// ==== verilog/directionVectorRam.sv ====
`timescale 1ns/1ps
`include "sobol_macros.svh"

module directionVectorRam (
    input  logic          clk,
    input  logic          reset,
    sobolStepIf.vecTable  bus
);

    // van der Corput seed, V[k] is this shifted right by k
    localparam logic [`OUTWD-1:0] vdcTopBit = {1'b1, {(`OUTWD-1){1'b0}}};

    logic [`OUTWD-1:0] vecs [`INWD];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < `INWD; k++) begin
                vecs[k] <= vdcTopBit >> k;
            end
        end else if (bus.dirWrite) begin
            vecs[bus.dirAddr] <= bus.dirData;
        end
    end

    assign bus.dirVec = vecs[bus.lszIdx]; // combinational read

endmodule

// ==== verilog/sobolAccumulator.sv ====
`timescale 1ns/1ps
`include "sobol_macros.svh"

module sobolAccumulator (
    input  logic              clk,
    input  logic              reset,
    output logic              outValid,
    output logic [`OUTWD-1:0] outData,
    sobolStepIf.acc           bus
);

    logic [`OUTWD-1:0] x;
    logic [`OUTWD-1:0] xNext;

    assign xNext = x ^ bus.dirVec;

    always_ff @(posedge clk) begin
        if (reset) begin
            x        <= '0;
            outValid <= 1'b0;
        end else begin
            outValid <= bus.step; // one cycle after the step
            if (bus.clear) begin
                x <= '0;
            end else if (bus.step) begin
                x <= xNext;
            end
        end
    end

    // sample register, only meaningful with outValid
    always_ff @(posedge clk) begin
        if (bus.step) begin
            outData <= xNext;
        end
    end

endmodule

// ==== verilog/sobolCtrl.sv ====
`timescale 1ns/1ps
`include "sobol_macros.svh"

module sobolCtrl import sobolPkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                cmdValid,
    input  sobolOp_t            cmdOp,
    input  logic [`LOGINWD-1:0] cmdAddr,
    input  logic [`OUTWD-1:0]   cmdData,
    input  logic                creditReturn, // one per freed sample
    output logic                running,
    sobolStepIf.ctrl            bus
);

    sobolState_t          state;
    sobolState_t          stateNext;
    logic [`CREDITWD-1:0] credits;   // samples the consumer can still take
    logic                 restartCmd;
    logic                 loadCmd;
    logic                 stepIssue;

    always_comb begin
        stateNext  = state;
        restartCmd = 1'b0;
        loadCmd    = 1'b0;
        if (cmdValid) begin
            case (cmdOp)
                OP_START: begin
                    stateNext = RUN;
                end
                OP_STOP: begin
                    stateNext = IDLE;
                end
                OP_RESTART: begin
                    restartCmd = 1'b1;
                end
                OP_LOADDIR: begin
                    loadCmd = (state == IDLE); // dropped while running
                end
                default: begin
                    stateNext = state;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= stateNext;
        end
    end

    // no step on the restart edge, so the first sample after it is V[0]
    assign stepIssue = (state == RUN) && (credits != '0) && !restartCmd;

    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= `CREDITWD'(`CREDITS);
        end else begin
            case ({stepIssue, creditReturn})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits; // none, or both cancel
            endcase
        end
    end

    assign running      = (state == RUN);
    assign bus.step     = stepIssue;
    assign bus.clear    = restartCmd;
    assign bus.dirWrite = loadCmd;
    assign bus.dirAddr  = cmdAddr;
    assign bus.dirData  = cmdData;

endmodule

// ==== verilog/sobolTop.sv ====
`timescale 1ns/1ps
`include "sobol_macros.svh"

module sobolTop import sobolPkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                cmdValid,
    input  sobolOp_t            cmdOp,
    input  logic [`LOGINWD-1:0] cmdAddr,
    input  logic [`OUTWD-1:0]   cmdData,
    input  logic                creditReturn,
    output logic                outValid,
    output logic [`OUTWD-1:0]   outData,
    output logic                running
);

    sobolStepIf i_stepIf ();

    sobolCtrl i_sobolCtrl (
        .clk          (clk),
        .reset        (reset),
        .cmdValid     (cmdValid),
        .cmdOp        (cmdOp),
        .cmdAddr      (cmdAddr),
        .cmdData      (cmdData),
        .creditReturn (creditReturn),
        .running      (running),
        .bus          (i_stepIf.ctrl)
    );

    // n and its lowest zero index
    sobolIndexCounter i_indexCounter (
        .clk   (clk),
        .reset (reset),
        .bus   (i_stepIf.counter)
    );

    directionVectorRam i_dirRam (
        .clk   (clk),
        .reset (reset),
        .bus   (i_stepIf.vecTable)
    );

    // x ^= V[c] and the output register
    sobolAccumulator i_accumulator (
        .clk      (clk),
        .reset    (reset),
        .outValid (outValid),
        .outData  (outData),
        .bus      (i_stepIf.acc)
    );

endmodule

// ==== dv/sobolTop_chk.sv ====
`timescale 1ns/1ps
`include "sobol_macros.svh"

module sobolTop_chk (
    input logic                 clk,
    input logic                 reset,
    input logic [`CREDITWD-1:0] credits,
    input logic                 step,
    input logic                 outValid,
    input logic                 running
);

    creditLimit: assert property (@(posedge clk) disable iff (reset)
        credits <= `CREDITWD'(`CREDITS))
        else $error("credit counter above its reset value");

    // a step needs RUN and a credit
    stepLegal: assert property (@(posedge clk) disable iff (reset)
        step |-> (running && credits != '0))
        else $error("step issued while idle or without credit");

    validAfterStep: assert property (@(posedge clk) disable iff (reset)
        step |=> outValid)
        else $error("outValid missing one cycle after step");

    noValidWithoutStep: assert property (@(posedge clk) disable iff (reset)
        !step |=> !outValid)
        else $error("outValid without a step one cycle earlier");

    runningInReset: assert property (@(posedge clk)
        reset |=> !running)
        else $error("running high during reset");

endmodule

bind sobolTop sobolTop_chk i_sobolTop_chk (
    .clk      (clk),
    .reset    (reset),
    .credits  (i_sobolCtrl.credits),
    .step     (i_stepIf.step),
    .outValid (outValid),
    .running  (running)
);

// ==== dv/sobolTb.sv ====
`timescale 1ns/1ps
`include "sobol_macros.svh"

module sobolTb import sobolPkg::*; ();

    localparam logic [31:0] lfsrTaps = 32'h8020_0003;

    logic                clk = 1'b0;
    logic                reset;
    logic                cmdValid;
    sobolOp_t            cmdOp;
    logic [`LOGINWD-1:0] cmdAddr;
    logic [`OUTWD-1:0]   cmdData;
    logic                creditReturn;
    logic                outValid;
    logic [`OUTWD-1:0]   outData;
    logic                running;

    logic [31:0]       lfsr = 32'hfa97_de0c;
    logic [`INWD-1:0]  mN;           // model counter
    logic [`OUTWD-1:0] mX;           // model sample
    logic [`OUTWD-1:0] mV [`INWD];   // model direction table
    logic              mRun;
    int                sinceStop;    // edges spent idle since a stop
    logic              sawWrap;
    int                samplesIn;
    int                creditsOut;
    int                delayCnt;     // cycles before next credit return
    logic              holdCredits;
    int                testErrors;
    int                totalErrors;
    int                testsRun;
    int                testsFailed;

    sobolTop i_sobolTop (
        .clk          (clk),
        .reset        (reset),
        .cmdValid     (cmdValid),
        .cmdOp        (cmdOp),
        .cmdAddr      (cmdAddr),
        .cmdData      (cmdData),
        .creditReturn (creditReturn),
        .outValid     (outValid),
        .outData      (outData),
        .running      (running)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] randBits(input int nbits);
        logic [31:0] r;
        logic        lsb;
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            lsb  = lfsr[0];
            lfsr = lfsr >> 1;
            if (lsb) begin
                lfsr = lfsr ^ lfsrTaps;
            end
            r = {r[30:0], lsb};
        end
        return r;
    endfunction

    // lowest 0 bit of n, all ones counts as 0
    function automatic int lowestZero(input logic [`INWD-1:0] n);
        int pos;
        pos = 0;
        while (pos < `INWD && n[pos]) begin
            pos++;
        end
        return (pos == `INWD) ? 0 : pos;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            testErrors++;
            $display("ERR %s expected 0x%h got 0x%h", name, exp, act);
        end
    endtask

    task automatic failNote(input string what);
        testErrors++;
        $display("%s", what);
    endtask

    task automatic sendCmd(input sobolOp_t op, input int addr, input logic [31:0] data);
        @(posedge clk);
        cmdValid <= 1'b1;
        cmdOp    <= op;
        cmdAddr  <= `LOGINWD'(addr);
        cmdData  <= data[`OUTWD-1:0];
        @(posedge clk);
        cmdValid <= 1'b0;
    endtask

    task automatic waitSamples(input int count, input int limit);
        int target;
        int cycles;
        @(negedge clk);
        target = samplesIn + count;
        cycles = 0;
        while (samplesIn < target && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        assert (samplesIn >= target) else failNote("timed out waiting for samples");
    endtask

    // all samples consumed, credits back, generator stopped
    task automatic waitIdle();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!(samplesIn == creditsOut && !outValid && !running) && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        assert (cycles < 200) else failNote("timed out waiting for the generator to drain");
    endtask

    task automatic finishTest(input string name);
        testsRun++;
        if (testErrors != 0) begin
            testsFailed++;
        end
        totalErrors += testErrors;
        $display("test %0d %s: %s, %0d errors", testsRun, name,
                 (testErrors == 0) ? "ok" : "failed", testErrors);
        testErrors = 0;
    endtask

    // reference model, monitor and credit returning consumer
    always @(posedge clk) begin : monitor
        int c;
        if (reset) begin
            mN           = '0;
            mX           = '0;
            mRun         = 1'b0;
            sinceStop    = 3;
            samplesIn    = 0;
            creditsOut   = 0;
            delayCnt     = 0;
            creditReturn <= 1'b0;
            for (int k = 0; k < `INWD; k++) begin
                mV[k]             = '0;
                mV[k][`OUTWD-1-k] = 1'b1; // van der Corput
            end
        end else begin
            if (!mRun && sinceStop < 3) begin
                sinceStop++;
            end
            if (outValid) begin
                assert (mRun || sinceStop <= 1)
                    else failNote("sample arrived more than one cycle after stop");
                c = lowestZero(mN);
                if (mN == '1) begin
                    sawWrap = 1'b1;
                end
                mX = mX ^ mV[c];
                mN = mN + 1'b1;
                checkValue("outData", mX, outData);
                samplesIn++;
                assert (samplesIn - creditsOut <= `CREDITS)
                    else failNote("consumer holds more samples than credits allow");
            end
            if (cmdValid) begin
                case (cmdOp)
                    OP_START: mRun = 1'b1;
                    OP_STOP: begin
                        if (mRun) begin
                            sinceStop = 0;
                        end
                        mRun = 1'b0;
                    end
                    OP_RESTART: begin
                        mN = '0;
                        mX = '0;
                    end
                    default: begin
                        if (!mRun) begin
                            mV[cmdAddr] = cmdData;
                        end
                    end
                endcase
            end
            creditReturn <= 1'b0;
            if (!holdCredits && samplesIn > creditsOut) begin
                if (delayCnt == 0) begin
                    creditReturn <= 1'b1;
                    creditsOut++;
                    delayCnt = randBits(3);
                end else begin
                    delayCnt--;
                end
            end
        end
    end

    initial begin
        logic [31:0] vec;
        int          base;
        int          cnt;
        reset        = 1'b1;
        cmdValid     = 1'b0;
        cmdOp        = OP_START;
        cmdAddr      = '0;
        cmdData      = '0;
        creditReturn = 1'b0;
        holdCredits  = 1'b0;
        sawWrap      = 1'b0;
        testErrors   = 0;
        totalErrors  = 0;
        testsRun     = 0;
        testsFailed  = 0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);

        checkValue("outValid", 0, outValid);
        checkValue("running", 0, running);
        sendCmd(OP_START, 0, 0);
        @(negedge clk);
        checkValue("running", 1, running);
        waitSamples(20, 400);
        sendCmd(OP_STOP, 0, 0);
        waitIdle();
        finishTest("reset table sequence");

        holdCredits = 1'b1; // consumer keeps every sample
        base = samplesIn;
        sendCmd(OP_START, 0, 0);
        repeat (30) @(negedge clk);
        checkValue("samples while held", `CREDITS, samplesIn - base);
        holdCredits = 1'b0;
        waitSamples(16, 400);
        sendCmd(OP_STOP, 0, 0);
        waitIdle();
        finishTest("credit back-pressure");

        for (int k = 0; k < `INWD; k++) begin
            vec = randBits(`OUTWD);
            sendCmd(OP_LOADDIR, k, vec);
        end
        sendCmd(OP_RESTART, 0, 0);
        sendCmd(OP_START, 0, 0);
        waitSamples(12, 300);
        vec = ~mV[0]; // differs from the entry in use
        sendCmd(OP_LOADDIR, 0, vec); // must be dropped in RUN
        waitSamples(12, 300);
        sendCmd(OP_STOP, 0, 0);
        waitIdle();
        finishTest("direction table load");

        sendCmd(OP_RESTART, 0, 0);
        sendCmd(OP_START, 0, 0);
        waitSamples(5, 200);
        sendCmd(OP_RESTART, 0, 0);
        @(negedge clk);
        checkValue("running", 1, running);
        waitSamples(10, 300);
        sendCmd(OP_STOP, 0, 0);
        @(negedge clk);
        checkValue("running", 0, running);
        cnt = samplesIn + (outValid ? 1 : 0); // one sample may still be in flight
        repeat (3) @(negedge clk);
        checkValue("samples after stop", cnt, samplesIn);
        waitIdle();
        finishTest("restart and stop");

        sawWrap = 1'b0;
        sendCmd(OP_RESTART, 0, 0);
        sendCmd(OP_START, 0, 0);
        waitSamples(300, 6000);
        sendCmd(OP_STOP, 0, 0);
        waitIdle();
        assert (sawWrap) else failNote("counter never stepped through all ones");
        finishTest("long run across counter wrap");

        $display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, totalErrors);
        if (totalErrors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== sobolTop.f ====
+incdir+verilog
verilog/sobolPkg.sv
verilog/sobolStepIf.sv
verilog/lszDetect.sv
verilog/sobolIndexCounter.sv
verilog/directionVectorRam.sv
verilog/sobolAccumulator.sv
verilog/sobolCtrl.sv
verilog/sobolTop.sv
dv/sobolTop_chk.sv
dv/sobolTb.sv

// ==== Bender.yml ====
package:
  name: sobol

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/sobolPkg.sv
      - verilog/sobolStepIf.sv
      - verilog/lszDetect.sv
      - verilog/sobolIndexCounter.sv
      - verilog/directionVectorRam.sv
      - verilog/sobolAccumulator.sv
      - verilog/sobolCtrl.sv
      - verilog/sobolTop.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/sobolTop_chk.sv
      - dv/sobolTb.sv
